// ==== logic/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    parameter int WORD_W   = 32;
    parameter int TAG_W    = 26;
    parameter int IDX_W    = 3;
    parameter int NUM_SETS = 8;

    // processor byte address as the cache sees it
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [IDX_W-1:0] idx;
        logic             blkoff;
        logic [1:0]       bytoff;
    } addr_t;

    typedef struct packed {
        logic                   valid;
        logic                   dirty;
        logic [TAG_W-1:0]       tag;
        logic [1:0][WORD_W-1:0] data;
    } frame_t;

    typedef enum logic [2:0] {
        acc_lookup,
        acc_wb_word0,
        acc_wb_word1,
        acc_fill_word0,
        acc_fill_word1,
        acc_halted
    } access_state_e;

    typedef enum logic [2:0] {
        fl_idle,
        fl_scan,
        fl_wb_word0,
        fl_wb_word1,
        fl_store_count,
        fl_done
    } flush_state_e;

    typedef enum logic {
        own_access,
        own_flush
    } owner_e;

endpackage

`default_nettype wire

// ==== logic/dcache_ifs.sv ====
`default_nettype none

// one engine's view of the tag/data array
interface set_port_if;
    logic [dcache_pkg::IDX_W-1:0] idx;
    logic                         way_sel;
    logic                         wr_en;
    dcache_pkg::frame_t           wr_frame;
    logic                         lru_touch;
    logic                         lru_way;
    dcache_pkg::frame_t [1:0]     rd_frames;
    logic                         lru;

    modport engine (
        output idx, way_sel, wr_en, wr_frame, lru_touch, lru_way,
        input  rd_frames, lru
    );

    modport array (
        input  idx, way_sel, wr_en, wr_frame, lru_touch, lru_way,
        output rd_frames, lru
    );
endinterface

// word port, request held until wait_n is seen high
interface mem_port_if;
    logic                          ren;
    logic                          wen;
    logic [dcache_pkg::WORD_W-1:0] addr;
    logic [dcache_pkg::WORD_W-1:0] store;
    logic [dcache_pkg::WORD_W-1:0] load;
    logic                          wait_n;

    modport client (
        output ren, wen, addr, store,
        input  load, wait_n
    );

    modport server (
        input  ren, wen, addr, store,
        output load, wait_n
    );
endinterface

`default_nettype wire

// ==== logic/set_array.sv ====
`default_nettype none

module set_array (
    input wire logic  CLK,
    input wire logic  nRST,
    set_port_if.array acc,
    set_port_if.array fl
);

    dcache_pkg::frame_t [1:0]            frames [dcache_pkg::NUM_SETS];
    logic [dcache_pkg::NUM_SETS-1:0]     lru_bits;

    // lookups are combinational on both ports
    always_comb begin
        acc.rd_frames = frames[acc.idx];
        acc.lru       = lru_bits[acc.idx];
        fl.rd_frames  = frames[fl.idx];
        fl.lru        = lru_bits[fl.idx];
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < dcache_pkg::NUM_SETS; i++) begin
                frames[i] <= '0;
            end
            lru_bits <= '0;
        end else begin
            if (fl.wr_en) begin
                frames[fl.idx][fl.way_sel] <= fl.wr_frame;
            end else if (acc.wr_en) begin
                frames[acc.idx][acc.way_sel] <= acc.wr_frame;
            end

            // lru names the way to evict next
            if (fl.lru_touch) begin
                lru_bits[fl.idx] <= ~fl.lru_way;
            end else if (acc.lru_touch) begin
                lru_bits[acc.idx] <= ~acc.lru_way;
            end
        end
    end

    // access and flush engines hand over at halt, never overlap
    assert property (@(posedge CLK) disable iff (!nRST)
        !(acc.wr_en && fl.wr_en))
        else $error("set_array written by both engines in one cycle");

endmodule

`default_nettype wire

// ==== logic/access_ctrl.sv ====
`default_nettype none

module access_ctrl (
    input wire logic                          CLK,
    input wire logic                          nRST,
    input wire logic                          dmem_ren,
    input wire logic                          dmem_wen,
    input wire dcache_pkg::addr_t             dmem_addr,
    input wire logic [dcache_pkg::WORD_W-1:0] dmem_store,
    input wire logic                          halt,
    output logic [dcache_pkg::WORD_W-1:0]     dmem_load,
    output logic                              dhit,
    set_port_if.engine                        set_if,
    mem_port_if.client                        mem_if,
    output logic                              flush_start,
    output logic [dcache_pkg::WORD_W-1:0]     hit_count
);

    dcache_pkg::access_state_e state, next_state;
    dcache_pkg::frame_t        hit_frame, victim;
    logic                      req, hit0, hit1, hit_way, victim_way, miss;

    assign req        = dmem_ren | dmem_wen;
    assign set_if.idx = dmem_addr.idx;

    assign hit0 = set_if.rd_frames[0].valid && (set_if.rd_frames[0].tag == dmem_addr.tag);
    assign hit1 = set_if.rd_frames[1].valid && (set_if.rd_frames[1].tag == dmem_addr.tag);
    assign hit_way   = ~hit0;
    assign hit_frame = set_if.rd_frames[hit_way];

    // lru is not touched during a miss, so the victim stays put
    assign victim_way = set_if.lru;
    assign victim     = set_if.rd_frames[victim_way];

    assign dmem_load   = hit_frame.data[dmem_addr.blkoff];
    assign flush_start = (state == dcache_pkg::acc_halted);

    always_comb begin
        next_state       = state;
        dhit             = 1'b0;
        miss             = 1'b0;
        set_if.wr_en     = 1'b0;
        set_if.way_sel   = victim_way;
        set_if.wr_frame  = victim;
        set_if.lru_touch = 1'b0;
        set_if.lru_way   = hit_way;
        mem_if.ren       = 1'b0;
        mem_if.wen       = 1'b0;
        mem_if.addr      = {dmem_addr.tag, dmem_addr.idx, 1'b0, 2'b00};
        mem_if.store     = victim.data[0];

        case (state)
            dcache_pkg::acc_lookup: begin
                if (req && (hit0 || hit1)) begin
                    dhit             = 1'b1;
                    set_if.lru_touch = 1'b1;
                    if (dmem_wen) begin
                        set_if.wr_en    = 1'b1;
                        set_if.way_sel  = hit_way;
                        set_if.wr_frame = hit_frame;
                        set_if.wr_frame.dirty = 1'b1;
                        set_if.wr_frame.data[dmem_addr.blkoff] = dmem_store;
                    end
                end else if (req) begin
                    miss = 1'b1;
                    next_state = victim.dirty ? dcache_pkg::acc_wb_word0
                                              : dcache_pkg::acc_fill_word0;
                end else if (halt) begin
                    next_state = dcache_pkg::acc_halted;
                end
            end
            dcache_pkg::acc_wb_word0: begin
                mem_if.wen  = 1'b1;
                mem_if.addr = {victim.tag, dmem_addr.idx, 1'b0, 2'b00};
                if (mem_if.wait_n) begin
                    next_state = dcache_pkg::acc_wb_word1;
                end
            end
            dcache_pkg::acc_wb_word1: begin
                mem_if.wen   = 1'b1;
                mem_if.addr  = {victim.tag, dmem_addr.idx, 1'b1, 2'b00};
                mem_if.store = victim.data[1];
                if (mem_if.wait_n) begin
                    next_state = dcache_pkg::acc_fill_word0;
                end
            end
            dcache_pkg::acc_fill_word0: begin
                mem_if.ren = 1'b1;
                if (mem_if.wait_n) begin
                    // tag goes in now but the frame stays invalid until word 1
                    set_if.wr_en    = 1'b1;
                    set_if.wr_frame = {1'b0, 1'b0, dmem_addr.tag, victim.data[1], mem_if.load};
                    next_state      = dcache_pkg::acc_fill_word1;
                end
            end
            dcache_pkg::acc_fill_word1: begin
                mem_if.ren  = 1'b1;
                mem_if.addr = {dmem_addr.tag, dmem_addr.idx, 1'b1, 2'b00};
                if (mem_if.wait_n) begin
                    set_if.wr_en    = 1'b1;
                    set_if.wr_frame = {1'b1, 1'b0, dmem_addr.tag, mem_if.load, victim.data[0]};
                    next_state      = dcache_pkg::acc_lookup;
                end
            end
            default: begin
                // halted for good, flush engine owns the array
            end
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state     <= dcache_pkg::acc_lookup;
            hit_count <= '0;
        end else begin
            state <= next_state;
            if (dhit) begin
                hit_count <= hit_count + 1'b1;
            end else if (miss) begin
                hit_count <= hit_count - 1'b1;
            end
        end
    end

    // processor side asks for one kind of access at a time
    assert property (@(posedge CLK) disable iff (!nRST)
        !(dmem_ren && dmem_wen))
        else $error("processor raised dmem_ren and dmem_wen together");

endmodule

`default_nettype wire

// ==== logic/flush_engine.sv ====
`default_nettype none

module flush_engine #(
    parameter logic [dcache_pkg::WORD_W-1:0] HIT_COUNT_ADDR = 32'h3100
) (
    input wire logic                          CLK,
    input wire logic                          nRST,
    input wire logic                          flush_start,
    input wire logic [dcache_pkg::WORD_W-1:0] hit_count,
    set_port_if.engine                        set_if,
    mem_port_if.client                        mem_if,
    output logic                              flushed
);

    dcache_pkg::flush_state_e     state, next_state;
    dcache_pkg::frame_t           f0, f1, wb_frame;
    logic [dcache_pkg::IDX_W-1:0] set_idx;
    logic                         wb_way, advance;

    assign set_if.idx = set_idx;
    assign f0 = set_if.rd_frames[0];
    assign f1 = set_if.rd_frames[1];

    // way 0 goes first when both are dirty
    assign wb_way   = ~f0.dirty;
    assign wb_frame = set_if.rd_frames[wb_way];

    // replacement order no longer matters once halted
    assign set_if.lru_touch = 1'b0;
    assign set_if.lru_way   = 1'b0;

    assign mem_if.ren = 1'b0;
    assign flushed    = (state == dcache_pkg::fl_done);

    always_comb begin
        next_state      = state;
        advance         = 1'b0;
        set_if.wr_en    = 1'b0;
        set_if.way_sel  = wb_way;
        set_if.wr_frame = '0;
        mem_if.wen      = 1'b0;
        mem_if.addr     = {wb_frame.tag, set_idx, 1'b0, 2'b00};
        mem_if.store    = wb_frame.data[0];

        case (state)
            dcache_pkg::fl_idle: begin
                if (flush_start) begin
                    next_state = dcache_pkg::fl_scan;
                end
            end
            dcache_pkg::fl_scan: begin
                if (f0.dirty || f1.dirty) begin
                    next_state = dcache_pkg::fl_wb_word0;
                end else begin
                    // clean frames are dropped, one write per cycle
                    set_if.wr_en   = f0.valid | f1.valid;
                    set_if.way_sel = ~f0.valid;
                    advance        = ~(f0.valid & f1.valid);
                    if (advance && set_idx == dcache_pkg::IDX_W'(dcache_pkg::NUM_SETS - 1)) begin
                        next_state = dcache_pkg::fl_store_count;
                    end
                end
            end
            dcache_pkg::fl_wb_word0: begin
                mem_if.wen = 1'b1;
                if (mem_if.wait_n) begin
                    next_state = dcache_pkg::fl_wb_word1;
                end
            end
            dcache_pkg::fl_wb_word1: begin
                mem_if.wen   = 1'b1;
                mem_if.addr  = {wb_frame.tag, set_idx, 1'b1, 2'b00};
                mem_if.store = wb_frame.data[1];
                if (mem_if.wait_n) begin
                    set_if.wr_en = 1'b1;
                    next_state   = dcache_pkg::fl_scan;
                end
            end
            dcache_pkg::fl_store_count: begin
                mem_if.wen   = 1'b1;
                mem_if.addr  = HIT_COUNT_ADDR;
                mem_if.store = hit_count;
                if (mem_if.wait_n) begin
                    next_state = dcache_pkg::fl_done;
                end
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state   <= dcache_pkg::fl_idle;
            set_idx <= '0;
        end else begin
            state <= next_state;
            if (advance) begin
                set_idx <= set_idx + 1'b1;
            end
        end
    end

    assert property (@(posedge CLK) disable iff (!nRST) flushed |=> flushed)
        else $error("flushed dropped before reset");

endmodule

`default_nettype wire

// ==== logic/mem_arbiter.sv ====
`default_nettype none

module mem_arbiter (
    input wire logic   CLK,
    input wire logic   nRST,
    mem_port_if.server acc,
    mem_port_if.server fl,
    mem_port_if.client mem
);

    dcache_pkg::owner_e owner, sel;
    logic               acc_req, fl_req, owner_req;

    assign acc_req   = acc.ren | acc.wen;
    assign fl_req    = fl.ren | fl.wen;
    assign owner_req = (owner == dcache_pkg::own_access) ? acc_req : fl_req;

    // keep a busy owner, otherwise access wins
    always_comb begin
        if (owner_req) begin
            sel = owner;
        end else if (acc_req) begin
            sel = dcache_pkg::own_access;
        end else if (fl_req) begin
            sel = dcache_pkg::own_flush;
        end else begin
            sel = owner;
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            owner <= dcache_pkg::own_access;
        end else begin
            owner <= sel;
        end
    end

    always_comb begin
        if (sel == dcache_pkg::own_access) begin
            mem.ren   = acc.ren;
            mem.wen   = acc.wen;
            mem.addr  = acc.addr;
            mem.store = acc.store;
        end else begin
            mem.ren   = fl.ren;
            mem.wen   = fl.wen;
            mem.addr  = fl.addr;
            mem.store = fl.store;
        end
    end

    assign acc.load   = (sel == dcache_pkg::own_access) ? mem.load : '0;
    assign acc.wait_n = (sel == dcache_pkg::own_access) && mem.wait_n;
    assign fl.load    = (sel == dcache_pkg::own_flush) ? mem.load : '0;
    assign fl.wait_n  = (sel == dcache_pkg::own_flush) && mem.wait_n;

    assert property (@(posedge CLK) disable iff (!nRST)
        (acc_req && sel == dcache_pkg::own_access) ##1 acc_req |-> sel == dcache_pkg::own_access)
        else $error("grant taken from access while its request was held");

    assert property (@(posedge CLK) disable iff (!nRST)
        (fl_req && sel == dcache_pkg::own_flush) ##1 fl_req |-> sel == dcache_pkg::own_flush)
        else $error("grant taken from flush engine while its request was held");

endmodule

`default_nettype wire

// ==== logic/dcache_top.sv ====
`default_nettype none

module dcache_top #(
    parameter logic [dcache_pkg::WORD_W-1:0] HIT_COUNT_ADDR = 32'h3100
) (
    input wire logic                          CLK,
    input wire logic                          nRST,
    input wire logic                          dmem_ren,
    input wire logic                          dmem_wen,
    input wire logic [dcache_pkg::WORD_W-1:0] dmem_addr,
    input wire logic [dcache_pkg::WORD_W-1:0] dmem_store,
    input wire logic                          halt,
    output logic [dcache_pkg::WORD_W-1:0]     dmem_load,
    output logic                              dhit,
    output logic                              flushed,
    input wire logic [dcache_pkg::WORD_W-1:0] mem_load,
    input wire logic                          mem_wait,
    output logic                              mem_ren,
    output logic                              mem_wen,
    output logic [dcache_pkg::WORD_W-1:0]     mem_addr,
    output logic [dcache_pkg::WORD_W-1:0]     mem_store
);

    set_port_if acc_set ();
    set_port_if fl_set ();
    mem_port_if acc_mem ();
    mem_port_if fl_mem ();
    mem_port_if mem_bus ();

    logic                          flush_start;
    logic [dcache_pkg::WORD_W-1:0] hit_count;

    assign mem_ren        = mem_bus.ren;
    assign mem_wen        = mem_bus.wen;
    assign mem_addr       = mem_bus.addr;
    assign mem_store      = mem_bus.store;
    assign mem_bus.load   = mem_load;
    assign mem_bus.wait_n = ~mem_wait;

    set_array u_set_array (
        .CLK  (CLK),
        .nRST (nRST),
        .acc  (acc_set.array),
        .fl   (fl_set.array)
    );

    access_ctrl u_access_ctrl (
        .CLK         (CLK),
        .nRST        (nRST),
        .dmem_ren    (dmem_ren),
        .dmem_wen    (dmem_wen),
        .dmem_addr   (dmem_addr),
        .dmem_store  (dmem_store),
        .halt        (halt),
        .dmem_load   (dmem_load),
        .dhit        (dhit),
        .set_if      (acc_set.engine),
        .mem_if      (acc_mem.client),
        .flush_start (flush_start),
        .hit_count   (hit_count)
    );

    flush_engine #(
        .HIT_COUNT_ADDR (HIT_COUNT_ADDR)
    ) u_flush_engine (
        .CLK         (CLK),
        .nRST        (nRST),
        .flush_start (flush_start),
        .hit_count   (hit_count),
        .set_if      (fl_set.engine),
        .mem_if      (fl_mem.client),
        .flushed     (flushed)
    );

    mem_arbiter u_mem_arbiter (
        .CLK  (CLK),
        .nRST (nRST),
        .acc  (acc_mem.server),
        .fl   (fl_mem.server),
        .mem  (mem_bus.client)
    );

endmodule

`default_nettype wire

// ==== test/mem_model.sv ====
`default_nettype none

module mem_model (
    input wire logic         CLK,
    input wire logic         nRST,
    input wire logic         mem_ren,
    input wire logic         mem_wen,
    input wire logic [31:0]  mem_addr,
    input wire logic [31:0]  mem_store,
    output logic [31:0]      mem_load,
    output logic             mem_wait,
    input wire logic [31:0]  peek_addr,
    output logic [31:0]      peek_data
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH = 4096;

    logic [31:0] words [DEPTH];
    logic [31:0] lcg_state;
    logic [1:0]  wait_left;
    logic        req;

    // wait cycles for the next request, 0 to 3
    function automatic logic [1:0] next_delay();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[17:16];
    endfunction

    assign req       = mem_ren | mem_wen;
    assign mem_wait  = req && (wait_left != 2'd0);
    assign mem_load  = words[mem_addr[13:2]];
    assign peek_data = words[peek_addr[13:2]];

    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            lcg_state = 32'd56;
            wait_left <= 2'd0;
            // every word starts as the inverse of its byte address
            for (int i = 0; i < DEPTH; i++) begin
                words[i] <= ~(32'(i) << 2);
            end
        end else if (req) begin
            if (wait_left != 2'd0) begin
                wait_left <= wait_left - 2'd1;
            end else begin
                if (mem_wen) begin
                    words[mem_addr[13:2]] <= mem_store;
                end
                wait_left <= next_delay();
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/dcache_tb.sv ====
`default_nettype none

module dcache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] COUNT_ADDR     = 32'h3100;
    localparam int          ACCESS_TIMEOUT = 200;
    localparam int          FLUSH_TIMEOUT  = 2000;

    logic        CLK, nRST;
    logic        dmem_ren, dmem_wen, halt, dhit, flushed;
    logic [31:0] dmem_addr, dmem_store, dmem_load;
    logic        mem_ren, mem_wen, mem_wait;
    logic [31:0] mem_addr, mem_store, mem_load;
    logic [31:0] peek_addr, peek_data, peek_exp;
    logic        peek_en;
    logic        first_cycle, want_hit, want_miss;
    logic [31:0] exp_load;
    string       test_name;
    logic [31:0] shadow [logic [31:0]];
    int unsigned first_hits;

    dcache_top #(
        .HIT_COUNT_ADDR (COUNT_ADDR)
    ) dut (
        .CLK        (CLK),
        .nRST       (nRST),
        .dmem_ren   (dmem_ren),
        .dmem_wen   (dmem_wen),
        .dmem_addr  (dmem_addr),
        .dmem_store (dmem_store),
        .halt       (halt),
        .dmem_load  (dmem_load),
        .dhit       (dhit),
        .flushed    (flushed),
        .mem_load   (mem_load),
        .mem_wait   (mem_wait),
        .mem_ren    (mem_ren),
        .mem_wen    (mem_wen),
        .mem_addr   (mem_addr),
        .mem_store  (mem_store)
    );

    mem_model mem_mod (
        .CLK       (CLK),
        .nRST      (nRST),
        .mem_ren   (mem_ren),
        .mem_wen   (mem_wen),
        .mem_addr  (mem_addr),
        .mem_store (mem_store),
        .mem_load  (mem_load),
        .mem_wait  (mem_wait),
        .peek_addr (peek_addr),
        .peek_data (peek_data)
    );

    task automatic stop_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic mismatch(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        $display("error %s: expected %h, actual %h", name, expected, actual);
        stop_run();
    endtask

    task automatic complain(input string what);
        $display("%s", what);
        stop_run();
    endtask

    // written words come from the shadow, the rest from the memory fill rule
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end else begin
            return ~addr;
        end
    endfunction

    task automatic access(input string name, input logic write, input logic [31:0] addr,
                          input logic [31:0] data, input logic hit_first,
                          input logic miss_first);
        int   cycles;
        logic got;
        cycles = 0;
        got    = 1'b0;
        @(negedge CLK);
        test_name = name;
        @(posedge CLK);
        dmem_ren    <= !write;
        dmem_wen    <= write;
        dmem_addr   <= addr;
        dmem_store  <= data;
        exp_load    <= expected_word(addr);
        want_hit    <= hit_first;
        want_miss   <= miss_first;
        first_cycle <= 1'b1;
        while (!got && cycles < ACCESS_TIMEOUT) begin
            @(negedge CLK);
            got = dhit;
            if (got && cycles == 0) begin
                first_hits++;
            end
            cycles++;
            @(posedge CLK);
            first_cycle <= 1'b0;
            if (got) begin
                dmem_ren <= 1'b0;
                dmem_wen <= 1'b0;
            end
        end
        if (!got) begin
            complain($sformatf("no dhit within %0d cycles in %s", ACCESS_TIMEOUT, name));
        end else if (write) begin
            shadow[addr] = data;
        end
    endtask

    task automatic wait_flushed();
        int   cycles;
        logic done;
        cycles = 0;
        done   = 1'b0;
        @(posedge CLK);
        halt <= 1'b1;
        while (!done && cycles < FLUSH_TIMEOUT) begin
            @(negedge CLK);
            done = flushed;
            cycles++;
        end
        if (!done) begin
            complain("flushed did not rise after halt before the timeout");
        end
    endtask

    assert property (@(posedge CLK) disable iff (!nRST)
        (dhit && dmem_ren) |-> dmem_load == exp_load)
        else mismatch(test_name, exp_load, $sampled(dmem_load));

    assert property (@(posedge CLK) disable iff (!nRST)
        (first_cycle && want_hit) |-> dhit)
        else mismatch(test_name, 32'd1, 32'($sampled(dhit)));

    assert property (@(posedge CLK) disable iff (!nRST)
        (first_cycle && want_miss) |-> !dhit)
        else mismatch(test_name, 32'd0, 32'($sampled(dhit)));

    assert property (@(posedge CLK) disable iff (!nRST)
        peek_en |-> peek_data == peek_exp)
        else mismatch(test_name, $sampled(peek_exp), $sampled(peek_data));

    assert property (@(posedge CLK) disable iff (!nRST) !(mem_ren && mem_wen))
        else complain("mem_ren and mem_wen were high together");

    // a waiting request must not move
    assert property (@(posedge CLK) disable iff (!nRST)
        ((mem_ren || mem_wen) && mem_wait) |=>
            ($stable(mem_addr) && $stable(mem_ren) && $stable(mem_wen)))
        else complain("memory request changed while it was held under wait");

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    initial begin
        nRST        = 1'b0;
        dmem_ren    = 1'b0;
        dmem_wen    = 1'b0;
        dmem_addr   = '0;
        dmem_store  = '0;
        halt        = 1'b0;
        peek_en     = 1'b0;
        peek_addr   = '0;
        peek_exp    = '0;
        first_cycle = 1'b0;
        want_hit    = 1'b0;
        want_miss   = 1'b0;
        exp_load    = '0;
        first_hits  = 0;
        test_name   = "reset";
        repeat (10) @(posedge CLK);
        nRST <= 1'b1;

        access("cold_read", 1'b0, 32'h0040, 32'h0, 1'b0, 1'b1);
        access("write_hit", 1'b1, 32'h0044, 32'ha5a5_0044, 1'b1, 1'b0);
        access("read_hit", 1'b0, 32'h0044, 32'h0, 1'b1, 1'b0);
        // write hit on a block that is already dirty
        access("dirty_write", 1'b1, 32'h0040, 32'h5a5a_0040, 1'b1, 1'b0);
        access("dirty_read", 1'b0, 32'h0040, 32'h0, 1'b1, 1'b0);

        // set 2, three tags
        access("evict_write_a", 1'b1, 32'h0410, 32'h1111_0410, 1'b0, 1'b1);
        access("evict_write_b", 1'b1, 32'h0810, 32'h2222_0810, 1'b0, 1'b1);
        access("evict_read_c", 1'b0, 32'h0c10, 32'h0, 1'b0, 1'b1);
        access("evict_read_a", 1'b0, 32'h0410, 32'h0, 1'b0, 1'b0);
        access("evict_read_b", 1'b0, 32'h0810, 32'h0, 1'b0, 1'b0);
        access("evict_read_a1", 1'b0, 32'h0414, 32'h0, 1'b0, 1'b0);

        // set 4, A touched last before C comes in
        access("lru_read_a", 1'b0, 32'h1020, 32'h0, 1'b0, 1'b1);
        access("lru_read_b", 1'b0, 32'h1420, 32'h0, 1'b0, 1'b1);
        access("lru_touch_a", 1'b0, 32'h1020, 32'h0, 1'b1, 1'b0);
        access("lru_read_c", 1'b0, 32'h1820, 32'h0, 1'b0, 1'b1);
        access("lru_keep_a", 1'b0, 32'h1020, 32'h0, 1'b1, 1'b0);
        access("lru_lost_b", 1'b0, 32'h1420, 32'h0, 1'b0, 1'b1);

        wait_flushed();
        test_name = "halt_memory";
        foreach (shadow[a]) begin
            @(posedge CLK);
            peek_en   <= 1'b1;
            peek_addr <= a;
            peek_exp  <= shadow[a];
        end
        @(posedge CLK);
        peek_en <= 1'b0;
        @(negedge CLK);
        test_name = "hit_count";
        @(posedge CLK);
        peek_en   <= 1'b1;
        peek_addr <= COUNT_ADDR;
        peek_exp  <= first_hits;
        @(posedge CLK);
        peek_en <= 1'b0;
        @(posedge CLK);
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
logic/dcache_pkg.sv
logic/dcache_ifs.sv
logic/set_array.sv
logic/access_ctrl.sv
logic/flush_engine.sv
logic/mem_arbiter.sv
logic/dcache_top.sv
test/mem_model.sv
test/dcache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f project.f --top-module dcache_tb -o dcache_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

output=$(./obj_dir/dcache_sim 2>&1)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Everything OK" <<< "$output"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
